// File: Bender.yml
package:
  name: dataMemory

sources:
  - files:
      - common/dataMemPkg.sv
      - common/laneIf.sv
      - dataMemory/storeAligner.sv
      - dataMemory/byteBank.sv
      - dataMemory/loadExtractor.sv
      - dataMemory/dataMemory.sv
  - target: test
    files:
      - testbench/clockGen.sv
      - testbench/dataMemory_sva.sv
      - testbench/dataMemoryTb.sv

// File: common/dataMemPkg.sv
`default_nettype none

package dataMemPkg;

    // Bus geometry
    localparam int AddrWidth   = 32;                     // Address and data width
    localparam int ByteWidth   = 8;
    localparam int HalfWidth   = 2 * ByteWidth;          // lh/sh payload
    localparam int LaneCount   = AddrWidth / ByteWidth;  // Four byte lanes
    localparam int OffsetWidth = $clog2(LaneCount);      // Byte offset inside a word

    // Bank depth
    localparam int MemWords       = 4096;                // Words per bank
    localparam int WordIndexWidth = $clog2(MemWords);    // Address bits 13:2

    // Access size as driven on ByteSig
    typedef enum logic [1:0] {
        sizeWord = 2'b00,   // lw / sw
        sizeHalf = 2'b01,   // lh / sh
        sizeByte = 2'b10,   // lb / sb
        sizeBad  = 2'b11    // Never legal
    } accessSizeT;

    // Row address shared by all banks
    typedef logic [WordIndexWidth-1:0] wordIndexT;

    // One byte per lane, lane 0 is the least significant byte
    typedef logic [LaneCount-1:0][ByteWidth-1:0] laneBytesT;

endpackage

`default_nettype wire

// File: common/laneIf.sv
`timescale 1ns/1ps
`default_nettype none

// Per-lane request from the store aligner to the byte banks
interface laneIf;
    import dataMemPkg::*;

    wordIndexT            wordIndex;    // Row in every bank
    logic [LaneCount-1:0] laneWrite;    // One write strobe per lane
    laneBytesT            laneData;     // Store data already placed on its lanes
    logic                 readEnable;   // Legal read in this cycle

    // Aligner side drives the whole request
    modport aligner (
        output wordIndex,
        output laneWrite,
        output laneData,
        output readEnable
    );

    // Banks only see the row, strobes and data
    modport bank (
        input wordIndex,
        input laneWrite,
        input laneData
    );

endinterface

`default_nettype wire

// File: dataMemory/byteBank.sv
`timescale 1ns/1ps
`default_nettype none

// One byte lane of the data memory
module byteBank #(
    parameter int LaneIndex = 0         // Which byte of the word this bank holds
) (
    input  logic                             Clock,
    laneIf.bank                              lanes,
    output logic [dataMemPkg::ByteWidth-1:0] readByte  // Valid one cycle after the request
);
    import dataMemPkg::*;

    logic [ByteWidth-1:0] mem [MemWords];   // Lane storage, no reset

    logic                 writeHit;         // This lane is written this cycle
    logic [ByteWidth-1:0] writeByte;        // Byte destined for this lane

    assign writeHit  = lanes.laneWrite[LaneIndex];
    assign writeByte = lanes.laneData[LaneIndex];

    // Write port
    always_ff @(posedge Clock) begin
        if (writeHit) begin
            mem[lanes.wordIndex] <= writeByte;
        end
    end

    // Registered read on every edge
    // A write to the same row in the same cycle shows up one access later
    always_ff @(posedge Clock) begin
        readByte <= mem[lanes.wordIndex];   // Old contents on collision
    end

endmodule

`default_nettype wire

// File: dataMemory/dataMemory.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemory (
    input  logic                             Clock,
    input  logic                             rstN,
    input  logic [dataMemPkg::AddrWidth-1:0] Address,
    input  logic [dataMemPkg::AddrWidth-1:0] WriteData,
    input  logic                             MemWrite,
    input  logic                             MemRead,
    input  dataMemPkg::accessSizeT           ByteSig,
    output logic [dataMemPkg::AddrWidth-1:0] ReadData
);
    import dataMemPkg::*;

    // Aligner to extractor
    accessSizeT             accessSize;
    logic [OffsetWidth-1:0] byteOffset;
    logic                   legal;

    laneBytesT laneBytes;   // Bank read bytes

    laneIf lanes ();        // Aligner to banks

    storeAligner aligner (
        .Address    (Address),
        .WriteData  (WriteData),
        .MemWrite   (MemWrite),
        .MemRead    (MemRead),
        .ByteSig    (ByteSig),
        .lanes      (lanes.aligner),
        .accessSize (accessSize),
        .byteOffset (byteOffset),
        .legal      (legal)
    );

    // One bank per byte lane
    for (genvar i = 0; i < LaneCount; i++) begin : genBank
        byteBank #(
            .LaneIndex (i)
        ) bank (
            .Clock    (Clock),
            .lanes    (lanes.bank),
            .readByte (laneBytes[i])
        );
    end

    loadExtractor extractor (
        .Clock      (Clock),
        .rstN       (rstN),
        .readEnable (lanes.readEnable),
        .legal      (legal),
        .accessSize (accessSize),
        .byteOffset (byteOffset),
        .laneBytes  (laneBytes),
        .ReadData   (ReadData)
    );

endmodule

`default_nettype wire

// File: dataMemory/loadExtractor.sv
`timescale 1ns/1ps
`default_nettype none

module loadExtractor (
    input  logic                               Clock,
    input  logic                               rstN,
    input  logic                               readEnable,   // Legal read requested
    input  logic                               legal,        // Aligner verdict on the access
    input  dataMemPkg::accessSizeT             accessSize,
    input  logic [dataMemPkg::OffsetWidth-1:0] byteOffset,
    input  dataMemPkg::laneBytesT              laneBytes,    // Bank outputs, one per lane
    output logic [dataMemPkg::AddrWidth-1:0]   ReadData
);
    import dataMemPkg::*;

    // Request state lined up with the bank read
    logic                   readEnableQ;
    logic                   legalQ;
    accessSizeT             sizeQ;
    logic [OffsetWidth-1:0] offsetQ;

    // Select path
    logic [AddrWidth-1:0] loadWord;   // Word assembled from the lanes
    logic [HalfWidth-1:0] halfSel;    // Addressed halfword
    logic [ByteWidth-1:0] byteSel;    // Addressed byte
    logic [AddrWidth-1:0] extended;   // Sign-extended result

    // Control state
    always_ff @(posedge Clock) begin
        if (!rstN) begin
            readEnableQ <= 1'b0;
            legalQ      <= 1'b0;
        end else begin
            readEnableQ <= readEnable;
            legalQ      <= legal;
        end
    end

    // Size and offset follow the bank address into the same edge
    always_ff @(posedge Clock) begin
        sizeQ   <= accessSize;
        offsetQ <= byteOffset;
    end

    assign loadWord = laneBytes;
    assign halfSel  = offsetQ[1] ? loadWord[AddrWidth-1:HalfWidth]
                                 : loadWord[HalfWidth-1:0];   // Offset 2 or 0
    assign byteSel  = laneBytes[offsetQ];

    // Sign extension by size
    always_comb begin
        case (sizeQ)
            sizeWord: extended = loadWord;
            sizeHalf: extended = {{(AddrWidth - HalfWidth){halfSel[HalfWidth-1]}}, halfSel};
            sizeByte: extended = {{(AddrWidth - ByteWidth){byteSel[ByteWidth-1]}}, byteSel};
            default:  extended = '0;   // Reserved size reads zero
        endcase
    end

    // Idle or illegal cycles read zero
    assign ReadData = (readEnableQ && legalQ) ? extended : '0;

endmodule

`default_nettype wire

// File: dataMemory/storeAligner.sv
`timescale 1ns/1ps
`default_nettype none

module storeAligner (
    input  logic [dataMemPkg::AddrWidth-1:0]   Address,
    input  logic [dataMemPkg::AddrWidth-1:0]   WriteData,
    input  logic                               MemWrite,
    input  logic                               MemRead,
    input  dataMemPkg::accessSizeT             ByteSig,
    laneIf.aligner                             lanes,
    output dataMemPkg::accessSizeT             accessSize,   // Size handed to the extractor
    output logic [dataMemPkg::OffsetWidth-1:0] byteOffset,   // Byte within the word
    output logic                               legal         // Size and offset agree
);
    import dataMemPkg::*;

    logic [OffsetWidth-1:0] offset;     // Low address bits
    logic [LaneCount-1:0]   laneMask;   // Lanes covered by the access
    laneBytesT              placedData; // Store data copied onto every lane

    assign offset = Address[OffsetWidth-1:0];

    // Size and offset decode
    always_comb begin
        legal      = 1'b0;
        laneMask   = '0;
        placedData = WriteData;             // Word goes out as is
        case (ByteSig)
            sizeWord: begin
                legal    = (offset == '0);  // Word must sit on a 4-byte boundary
                laneMask = '1;
            end
            sizeHalf: begin
                legal      = ~offset[0];    // Even addresses only
                laneMask   = offset[1] ? 4'b1100 : 4'b0011;
                placedData = {2{WriteData[HalfWidth-1:0]}};
            end
            sizeByte: begin
                legal      = 1'b1;          // Any offset is fine
                laneMask   = 4'b0001 << offset;
                placedData = {LaneCount{WriteData[ByteWidth-1:0]}};
            end
            sizeBad: begin
                // Reserved encoding touches nothing
                legal    = 1'b0;
                laneMask = '0;
            end
        endcase
    end

    // Request to the banks
    assign lanes.wordIndex  = Address[OffsetWidth +: WordIndexWidth]; // Wraps on the low bits
    assign lanes.laneData   = placedData;
    assign lanes.laneWrite  = (MemWrite && legal) ? laneMask : '0;
    assign lanes.readEnable = MemRead && legal;

    // Side info for the load path
    assign accessSize = ByteSig;
    assign byteOffset = offset;

endmodule

`default_nettype wire

// File: src.f
common/dataMemPkg.sv
common/laneIf.sv
dataMemory/storeAligner.sv
dataMemory/byteBank.sv
dataMemory/loadExtractor.sv
dataMemory/dataMemory.sv
testbench/clockGen.sv
testbench/dataMemory_sva.sv
testbench/dataMemoryTb.sv

// File: testbench/clockGen.sv
`timescale 1ns/1ps
`default_nettype none

// Free-running clock and power-on reset for the testbench
module clockGen (
    output logic Clock,
    output logic rstN
);
    localparam realtime HalfPeriod  = 2ns;  // 4 ns period
    localparam int      ResetCycles = 3;    // Edges with rstN held low

    initial begin
        Clock = 1'b0;
        forever #(HalfPeriod) Clock = ~Clock;
    end

    // Release on an edge so the reset stays synchronous
    initial begin
        rstN = 1'b0;
        repeat (ResetCycles) @(posedge Clock);
        rstN <= 1'b1;
    end

endmodule

`default_nettype wire

// File: testbench/dataMemoryTb.sv
`timescale 1ns/1ps
`default_nettype none

module dataMemoryTb;
    import dataMemPkg::*;

    localparam string       StimPath    = "testbench/dataMemory_stim.txt";
    localparam int          RandomCount = 200;           // Random accesses
    localparam logic [31:0] RandBase    = 32'h0000_2000; // Region kept apart from directed tests
    localparam int          RandWords   = 16;
    localparam int          RandBytes   = RandWords * 4;
    localparam logic [31:0] RandomSeed  = 32'h93181afd;

    // DUT signals
    logic        Clock;
    logic        rstN;
    logic [31:0] Address;
    logic [31:0] WriteData;
    logic        MemWrite;
    logic        MemRead;
    accessSizeT  ByteSig;
    logic [31:0] ReadData;

    // Expected value pipeline, one entry per driven cycle
    logic        reqCheck;
    logic [31:0] reqExpect;
    logic        chkValid;
    logic [31:0] chkExpect;

    // Directed access list
    byte         opQ[$];
    logic [1:0]  sizeQ[$];
    logic [31:0] addrQ[$];
    logic [31:0] dataQ[$];
    logic [31:0] expQ[$];

    logic [7:0] shadow [RandBytes];   // Byte image of the random region

    int cycleCount = 0;
    int cycleLimit = 0;   // Zero until the stim file is loaded

    clockGen clocks (
        .Clock (Clock),
        .rstN  (rstN)
    );

    dataMemory DUT (
        .Clock     (Clock),
        .rstN      (rstN),
        .Address   (Address),
        .WriteData (WriteData),
        .MemWrite  (MemWrite),
        .MemRead   (MemRead),
        .ByteSig   (ByteSig),
        .ReadData  (ReadData)
    );

    bind dataMemory dataMemory_sva sva (
        .Clock       (Clock),
        .rstN        (rstN),
        .Address     (Address),
        .ByteSig     (ByteSig),
        .MemRead     (MemRead),
        .legal       (legal),
        .laneWrite   (lanes.laneWrite),
        .readEnableQ (extractor.readEnableQ),
        .ReadData    (ReadData)
    );

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            $display("Result: FAILED");
            $fatal(1, "Value check failed");
        end
    endtask

    // One access per rising edge, expectation travels alongside
    task automatic driveAccess(input logic rd, input logic wr, input logic [1:0] size,
                               input logic [31:0] addr, input logic [31:0] data,
                               input logic [31:0] expectedData);
        @(posedge Clock);
        MemRead   <= rd;
        MemWrite  <= wr;
        ByteSig   <= accessSizeT'(size);
        Address   <= addr;
        WriteData <= data;
        reqCheck  <= 1'b1;
        reqExpect <= rd ? expectedData : 32'h0;   // No read means zero
    endtask

    task automatic loadStimulus();
        int    fd;
        int    fields;
        string line;
        byte   op;
        logic [31:0] sizeVal;
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] expVal;
        fd = $fopen(StimPath, "r");
        if (fd == 0) begin
            $display("Cannot open the stimulus file %s", StimPath);
            $display("Result: FAILED");
            $fatal(1, "Missing stimulus file");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 0 && line.getc(0) != "#") begin   // Skip comments
                fields = $sscanf(line, "%c %h %h %h %h", op, sizeVal, addr, data, expVal);
                if (fields == 5) begin
                    opQ.push_back(op);
                    sizeQ.push_back(sizeVal[1:0]);
                    addrQ.push_back(addr);
                    dataQ.push_back(data);
                    expQ.push_back(expVal);
                end
            end
        end
        $fclose(fd);
    endtask

    // Fill pattern over the whole address
    function automatic logic [31:0] fillWord(input logic [31:0] addr);
        fillWord = addr ^ (addr << 13) ^ 32'hA5C3_0F96;
    endfunction

    // Little endian update, lane 0 holds the low byte
    task automatic storeShadow(input logic [1:0] size, input int off, input logic [31:0] data);
        case (size)
            2'd0: begin
                for (int b = 0; b < 4; b++) begin
                    shadow[off + b] = data[8*b +: 8];
                end
            end
            2'd1: begin
                shadow[off]     = data[7:0];
                shadow[off + 1] = data[15:8];
            end
            default: shadow[off] = data[7:0];
        endcase
    endtask

    function automatic logic [31:0] predictLoad(input logic [1:0] size, input int off);
        case (size)
            2'd0:    predictLoad = {shadow[off + 3], shadow[off + 2], shadow[off + 1], shadow[off]};
            2'd1:    predictLoad = {{16{shadow[off + 1][7]}}, shadow[off + 1], shadow[off]};
            default: predictLoad = {{24{shadow[off][7]}}, shadow[off]};   // Sign from bit 7
        endcase
    endfunction

    // Expectation lines up with ReadData one edge later
    always @(posedge Clock) begin
        chkValid  <= reqCheck;
        chkExpect <= reqExpect;
    end

    // Sample away from the edge
    always @(negedge Clock) begin
        if (chkValid) begin
            checkValue("ReadData", ReadData, chkExpect);
        end
    end

    always @(posedge Clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleLimit != 0 && cycleCount >= cycleLimit) begin
            $display("Timeout: run went past %0d cycles", cycleLimit);
            $display("Result: FAILED");
            $fatal(1, "Run timed out");
        end
    end

    initial begin
        logic [1:0]  sizeVal;
        logic [31:0] randData;
        int          off;
        logic        isWrite;

        // Legal word read held through reset, the registered enable must stay low
        Address   = 32'h0;
        WriteData = 32'h0;
        MemWrite  = 1'b0;
        MemRead   = 1'b1;
        ByteSig   = sizeWord;
        reqCheck  = 1'b0;
        reqExpect = 32'h0;
        chkValid  = 1'b0;
        chkExpect = 32'h0;
        void'($urandom(RandomSeed));

        loadStimulus();
        cycleLimit = 2 * opQ.size() + RandomCount + 50;

        wait (rstN === 1'b1);
        MemRead <= 1'b0;   // Bus idle once reset is released

        // Directed list
        foreach (opQ[i]) begin
            case (opQ[i])
                "W": driveAccess(1'b0, 1'b1, sizeQ[i], addrQ[i], dataQ[i], expQ[i]);
                "R": driveAccess(1'b1, 1'b0, sizeQ[i], addrQ[i], dataQ[i], expQ[i]);
                "X": driveAccess(1'b1, 1'b1, sizeQ[i], addrQ[i], dataQ[i], expQ[i]);
                "N": driveAccess(1'b0, 1'b0, sizeQ[i], addrQ[i], dataQ[i], expQ[i]);
                default: begin
                    $display("Unknown operation on stimulus line %0d", i);
                    $display("Result: FAILED");
                    $fatal(1, "Bad stimulus file");
                end
            endcase
        end

        // Known contents for the random region
        for (int w = 0; w < RandWords; w++) begin
            driveAccess(1'b0, 1'b1, 2'd0, RandBase + 4 * w, fillWord(RandBase + 4 * w), 32'h0);
            storeShadow(2'd0, 4 * w, fillWord(RandBase + 4 * w));
        end

        // Random legal mix against the shadow image
        repeat (RandomCount) begin
            sizeVal  = 2'($urandom_range(2, 0));
            off      = $urandom_range(RandBytes - 1, 0);
            isWrite  = 1'($urandom_range(1, 0));
            randData = $urandom;
            if (sizeVal == 2'd0) begin
                off = off & ~3;   // Word aligned
            end else if (sizeVal == 2'd1) begin
                off = off & ~1;   // Even address
            end
            if (isWrite) begin
                driveAccess(1'b0, 1'b1, sizeVal, RandBase + off, randData, 32'h0);
                storeShadow(sizeVal, off, randData);
            end else begin
                driveAccess(1'b1, 1'b0, sizeVal, RandBase + off, randData,
                            predictLoad(sizeVal, off));
            end
        end

        // Drain the last checks
        driveAccess(1'b0, 1'b0, 2'd0, 32'h0, 32'h0, 32'h0);
        driveAccess(1'b0, 1'b0, 2'd0, 32'h0, 32'h0, 32'h0);
        repeat (3) @(posedge Clock);

        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: testbench/dataMemory_stim.txt
# op size address writeData expectedReadData (hex)
# op W store, R load, X load and store in one cycle, N idle; size 0 word 1 half 2 byte 3 bad
W 0 00000010 12345678 00000000
R 0 00000010 00000000 12345678
W 0 00000020 00000000 00000000
W 1 00000020 0000ABCD 00000000
R 0 00000020 00000000 0000ABCD
W 1 00000022 00001234 00000000
R 0 00000020 00000000 1234ABCD
R 1 00000020 00000000 FFFFABCD
R 1 00000022 00000000 00001234
W 2 00000030 000000F1 00000000
W 2 00000031 00000022 00000000
W 2 00000032 00000083 00000000
W 2 00000033 00000044 00000000
R 2 00000030 00000000 FFFFFFF1
R 2 00000031 00000000 00000022
R 2 00000032 00000000 FFFFFF83
R 2 00000033 00000000 00000044
R 0 00000030 00000000 448322F1
W 1 00000011 0000FFFF 00000000
W 0 00000012 AAAAAAAA 00000000
W 3 00000010 55555555 00000000
R 0 00000010 00000000 12345678
R 1 00000011 00000000 00000000
R 0 00000012 00000000 00000000
R 3 00000010 00000000 00000000
N 0 00000010 00000000 00000000
X 0 00000010 CAFEF00D 12345678
R 0 00000010 00000000 CAFEF00D
R 0 00000020 00000000 1234ABCD
R 0 00000030 00000000 448322F1

// File: testbench/dataMemory_sva.sv
`timescale 1ns/1ps
`default_nettype none

// Protocol checks on the data memory internals
module dataMemory_sva (
    input logic        Clock,
    input logic        rstN,
    input logic [31:0] Address,       // Raw access address
    input logic [1:0]  ByteSig,       // Raw access size
    input logic        MemRead,
    input logic        legal,         // Aligner verdict
    input logic [3:0]  laneWrite,     // Bank write strobes
    input logic        readEnableQ,   // Extractor registered enable
    input logic [31:0] ReadData
);

    logic badAccess;   // Reserved size or offset not matching the size

    assign badAccess = (ByteSig == 2'b11)
                    || (ByteSig == 2'b00 && Address[1:0] != 2'b00)
                    || (ByteSig == 2'b01 && Address[0]);

    // Illegal access is flagged and never reaches a bank
    noWriteWhenIllegal: assert property (
        @(posedge Clock) badAccess |-> (!legal && laneWrite == 4'b0000)
    ) else $error("Illegal access was not blocked by the aligner");

    // Registered enable is cleared by reset
    enableLowAfterReset: assert property (
        @(posedge Clock) !rstN |=> !readEnableQ
    ) else $error("Registered read enable still high after reset");

    // Cycle without a read gives zero on the next cycle
    zeroWithoutRead: assert property (
        @(posedge Clock) disable iff (!rstN)
        !MemRead |=> (ReadData == 32'h0)
    ) else $error("ReadData nonzero after a cycle with MemRead low");

endmodule

`default_nettype wire
